// ==== verilog/cheat_pkg.sv ====
/*
 Types and port map shared by the cheat hub blocks.
 Port ids are the 8-bit ids of the controller port bus.
 Ids 0x40-0x7F kick the watchdog, ids 0x80 and up request SDRAM.
*/
package cheat_pkg;

    typedef logic [ 7:0] byte_t;   // Port value or port id
    typedef logic [15:0] word_t;   // SDRAM data
    typedef logic [ 1:0] mask_t;   // SDRAM byte mask
    typedef logic [31:0] stamp_t;  // Time value

    // SDRAM request registers, address 0-2, data 3-4, mask 5
    localparam byte_t PORT_SD_ADDR   = 8'h00;
    localparam byte_t PORT_SD_MASK   = 8'h05;
    localparam byte_t PORT_LED       = 8'h06;  // Write side
    localparam byte_t PORT_SD_LO     = 8'h06;  // Read side, captured SDRAM low byte
    localparam byte_t PORT_SD_HI     = 8'h07;
    localparam byte_t PORT_VRAM_LO   = 8'h08;
    localparam byte_t PORT_VRAM_HI   = 8'h09;
    localparam byte_t PORT_VRAM_DATA = 8'h0A;
    localparam byte_t PORT_VRAM_CTRL = 8'h0B;
    localparam byte_t PORT_ST_ADDR   = 8'h0C;
    localparam byte_t PORT_ST_DATA   = 8'h0D;
    localparam byte_t PORT_DEBUG     = 8'h0F;
    localparam byte_t PORT_FLAGS     = 8'h10;  // Four bytes
    localparam byte_t PORT_JOY       = 8'h18;
    localparam byte_t PORT_TIMESTAMP = 8'h20;  // Four bytes each from here
    localparam byte_t PORT_BUILD     = 8'h24;
    localparam byte_t PORT_CUR_TIME  = 8'h28;
    localparam byte_t PORT_FRAME     = 8'h2C;
    localparam byte_t PORT_KEY       = 8'h30;
    localparam byte_t PORT_SD_REQ    = 8'h80;  // 0x80-0xBF read, 0xC0-0xFF write
    localparam byte_t PORT_SD_WR     = 8'hC0;
    localparam byte_t PORT_STATUS    = 8'h80;  // Read only

    localparam logic [1:0] PORT_KICK_TOP = 2'b01;

    localparam int FRAMES_PER_SEC = 60;
    localparam int WDOG_FRAMES    = 8;

endpackage

// ==== verilog/frame_timer.sv ====
/*
 Uptime counters and frame watchdog.
 A frame ends when lvbl is first sampled low after being high.
 ctrl_reset stays high until a kick arrives; it does not reset this block.
*/
module frame_timer (
    input  logic        clk,
    input  logic        prst,
    input  logic        lvbl,
    input  logic        kick,
    output logic [ 5:0] frame_cnt,
    output logic [23:0] sec_cnt,
    output logic        ctrl_reset
);
    localparam int WDW = $clog2(cheat_pkg::WDOG_FRAMES + 1);

    logic           lvbl_last;
    logic           frame_end;
    logic [WDW-1:0] wdog_cnt;

    assign frame_end  = lvbl_last & ~lvbl;
    assign ctrl_reset = wdog_cnt >= WDW'(cheat_pkg::WDOG_FRAMES);

    always_ff @(posedge clk) begin
        if (prst) begin
            lvbl_last <= 1'b0;
            frame_cnt <= '0;
            sec_cnt   <= '0;
        end else begin
            lvbl_last <= lvbl;
            if (frame_end) begin
                if (frame_cnt == 6'(cheat_pkg::FRAMES_PER_SEC - 1)) begin
                    frame_cnt <= '0;
                    sec_cnt   <= sec_cnt + 24'd1;  // Wraps after about 194 days
                end else begin
                    frame_cnt <= frame_cnt + 6'd1;
                end
            end
        end
    end

    // Frames since last kick, held once it trips
    always_ff @(posedge clk) begin
        if (prst) begin
            wdog_cnt <= '0;
        end else if (kick) begin
            wdog_cnt <= '0;
        end else if (frame_end && !ctrl_reset) begin
            wdog_cnt <= wdog_cnt + 1'b1;
        end
    end

    frame_range_a: assert property (@(posedge clk) disable iff (prst)
        frame_cnt < 6'(cheat_pkg::FRAMES_PER_SEC));

endmodule

// ==== verilog/port_regs.sv ====
/*
 Write side of the port bus.
 AW must not exceed 24, the address is built from three port bytes.
 UNLOCK_KEY must be nonzero or the lock opens right after reset.
 Strobes are assumed never to come on consecutive cycles.
*/
module port_regs #(
    parameter int                AW         = 22,
    parameter cheat_pkg::stamp_t UNLOCK_KEY = 32'h5A3C_96E1
) (
    input  logic              clk,
    input  logic              prst,
    input  cheat_pkg::byte_t  port_id,
    input  cheat_pkg::byte_t  port_out,
    input  logic              write_strobe,
    input  logic              k_write_strobe,
    output logic [AW-1:0]     ctrl_addr,
    output cheat_pkg::word_t  ctrl_din,
    output cheat_pkg::mask_t  ctrl_din_m,
    output logic              req_set,
    output logic              req_wr,
    output logic              kick,
    output logic [47:0]       sdram_bytes,
    output logic [ 9:0]       vram_addr,
    output cheat_pkg::byte_t  vram_dout,
    output logic              vram_we,
    output logic [ 2:0]       vram_ctrl,
    output cheat_pkg::byte_t  st_addr,
    output logic [ 1:0]       led,
    output logic              locked
);
    cheat_pkg::byte_t  sd_reg [6];
    cheat_pkg::stamp_t key;
    logic [23:0]       addr24;
    logic              any_wr;

    assign any_wr = write_strobe | k_write_strobe;

    assign sdram_bytes = {sd_reg[5], sd_reg[4], sd_reg[3], sd_reg[2], sd_reg[1], sd_reg[0]};
    assign addr24      = {sd_reg[2], sd_reg[1], sd_reg[0]};
    assign ctrl_addr   = addr24[AW-1:0];
    assign ctrl_din    = {sd_reg[4], sd_reg[3]};
    assign ctrl_din_m  = sd_reg[5][1:0];

    // Constant writes cannot start an SDRAM access or kick the watchdog
    assign req_set = write_strobe && port_id >= cheat_pkg::PORT_SD_REQ;
    assign req_wr  = port_id >= cheat_pkg::PORT_SD_WR;
    assign kick    = write_strobe && port_id[7:6] == cheat_pkg::PORT_KICK_TOP;

    assign locked = key != UNLOCK_KEY;

    always_ff @(posedge clk) begin
        if (prst) begin
            vram_we   <= 1'b0;
            vram_ctrl <= '0;
            led       <= '0;
            key       <= '0;
        end else begin
            vram_we <= 1'b0;  // Single cycle pulse
            if (any_wr) begin
                case (port_id)
                    cheat_pkg::PORT_VRAM_DATA: vram_we   <= 1'b1;
                    cheat_pkg::PORT_VRAM_CTRL: vram_ctrl <= port_out[2:0];
                    cheat_pkg::PORT_LED:       led       <= port_out[1:0];
                    default: ;
                endcase
            end
            if (write_strobe && port_id[7:2] == cheat_pkg::PORT_KEY[7:2]) begin
                key[8*port_id[1:0] +: 8] <= port_out;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any_wr) begin
            if (port_id <= cheat_pkg::PORT_SD_MASK) begin
                sd_reg[port_id[2:0]] <= port_out;
            end
            case (port_id)
                cheat_pkg::PORT_VRAM_LO:   vram_addr[4:0] <= port_out[4:0];
                cheat_pkg::PORT_VRAM_HI:   vram_addr[9:5] <= port_out[4:0];
                cheat_pkg::PORT_VRAM_DATA: vram_dout      <= {1'b1, port_out[6:0]};  // MSB marks cheat text
                cheat_pkg::PORT_ST_ADDR:   st_addr        <= port_out;
                default: ;
            endcase
        end
    end

    vram_we_pulse_a: assert property (@(posedge clk) disable iff (prst)
        vram_we |=> !vram_we);

endmodule

// ==== verilog/port_read_mux.sv ====
/*
 Read side of the port bus.
 port_in is registered on read_strobe and holds until the next read.
 Unmapped ids read as zero. Current time is timestamp plus uptime seconds.
*/
module port_read_mux #(
    parameter cheat_pkg::stamp_t BUILD_TIME = 32'h0
) (
    input  logic              clk,
    input  logic              prst,
    input  cheat_pkg::byte_t  port_id,
    input  logic              read_strobe,
    input  logic [47:0]       sdram_bytes,
    input  cheat_pkg::word_t  ctrl_rdata,
    input  cheat_pkg::byte_t  vram_din,
    input  cheat_pkg::byte_t  st_dout,
    input  cheat_pkg::byte_t  debug_bus,
    input  cheat_pkg::stamp_t flags,
    input  cheat_pkg::byte_t  joy0,
    input  cheat_pkg::stamp_t timestamp,
    input  logic [ 5:0]       frame_cnt,
    input  logic [23:0]       sec_cnt,
    input  logic              owner,
    input  logic              ctrl_busy,
    input  logic              lvbl,
    input  logic              locked,
    output cheat_pkg::byte_t  port_in
);
    cheat_pkg::stamp_t cur_time;
    cheat_pkg::byte_t  rd_byte;

    function automatic cheat_pkg::byte_t pick(cheat_pkg::stamp_t v, logic [1:0] idx);
        return v[8*idx +: 8];
    endfunction

    assign cur_time = timestamp + {8'd0, sec_cnt};

    always_comb begin
        rd_byte = '0;
        case (port_id) inside
            [cheat_pkg::PORT_SD_ADDR:cheat_pkg::PORT_SD_MASK]:
                rd_byte = sdram_bytes[8*port_id[2:0] +: 8];
            cheat_pkg::PORT_SD_LO:     rd_byte = ctrl_rdata[7:0];
            cheat_pkg::PORT_SD_HI:     rd_byte = ctrl_rdata[15:8];
            cheat_pkg::PORT_VRAM_DATA: rd_byte = vram_din;
            cheat_pkg::PORT_ST_DATA:   rd_byte = st_dout;
            cheat_pkg::PORT_DEBUG:     rd_byte = debug_bus;
            [cheat_pkg::PORT_FLAGS:cheat_pkg::PORT_FLAGS+3]:
                rd_byte = pick(flags, port_id[1:0]);
            cheat_pkg::PORT_JOY:       rd_byte = joy0;
            [cheat_pkg::PORT_TIMESTAMP:cheat_pkg::PORT_TIMESTAMP+3]:
                rd_byte = pick(timestamp, port_id[1:0]);
            [cheat_pkg::PORT_BUILD:cheat_pkg::PORT_BUILD+3]:
                rd_byte = pick(BUILD_TIME, port_id[1:0]);
            [cheat_pkg::PORT_CUR_TIME:cheat_pkg::PORT_CUR_TIME+3]:
                rd_byte = pick(cur_time, port_id[1:0]);
            cheat_pkg::PORT_FRAME:     rd_byte = {2'd0, frame_cnt};
            // 0xC0 here means the controller access is still running
            cheat_pkg::PORT_STATUS:    rd_byte = {owner, ctrl_busy, lvbl, 4'd0, locked};
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (prst) begin
            port_in <= '0;
        end else if (read_strobe) begin
            port_in <= rd_byte;
        end
    end

endmodule

// ==== verilog/sdram_arbiter.sv ====
/*
 Shares SDRAM bank 0 between the game and the controller.
 The game wins whenever the arbiter is idle. Requests hold until ack,
 dst marks valid read data and rdy closes the access.
 While idle the game request goes straight to the bank.
*/
module sdram_arbiter #(
    parameter int AW = 22
) (
    input  logic              clk,
    input  logic              prst,
    input  logic [AW-1:0]     game_addr,
    input  logic              game_rd,
    input  logic              game_wr,
    input  cheat_pkg::word_t  game_din,
    input  cheat_pkg::mask_t  game_din_m,
    output logic              game_ack,
    output logic              game_dst,
    output logic              game_rdy,
    output logic [AW-1:0]     ba0_addr,
    output logic              ba0_rd,
    output logic              ba0_wr,
    output cheat_pkg::word_t  ba0_din,
    output cheat_pkg::mask_t  ba0_din_m,
    input  logic              ba0_ack,
    input  logic              ba0_dst,
    input  logic              ba0_rdy,
    input  cheat_pkg::word_t  data_read,
    input  logic [AW-1:0]     ctrl_addr,
    input  cheat_pkg::word_t  ctrl_din,
    input  cheat_pkg::mask_t  ctrl_din_m,
    input  logic              req_set,
    input  logic              req_wr,
    output cheat_pkg::word_t  ctrl_rdata,
    output logic              owner,
    output logic              ctrl_busy
);
    typedef enum logic [1:0] {ST_IDLE, ST_GAME, ST_CTRL} arb_state_t;

    arb_state_t state;
    logic       pend;     // Controller request not yet acked
    logic       pend_wr;

    assign owner     = state == ST_CTRL;
    assign ctrl_busy = pend | owner;

    always_ff @(posedge clk) begin
        if (prst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (game_rd || game_wr) begin
                        state <= ST_GAME;
                    end else if (pend) begin
                        state <= ST_CTRL;
                    end
                end
                ST_GAME, ST_CTRL: begin
                    if (ba0_rdy) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (prst) begin
            pend    <= 1'b0;
            pend_wr <= 1'b0;
        end else if (req_set) begin
            pend    <= 1'b1;
            pend_wr <= req_wr;
        end else if (owner && ba0_ack) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (owner && ba0_dst) begin
            ctrl_rdata <= data_read;
        end
    end

    always_comb begin
        ba0_addr  = owner ? ctrl_addr  : game_addr;
        ba0_rd    = owner ? (pend & ~pend_wr) : game_rd;
        ba0_wr    = owner ? (pend &  pend_wr) : game_wr;
        ba0_din   = owner ? ctrl_din   : game_din;
        ba0_din_m = owner ? ctrl_din_m : game_din_m;
        game_ack  = ~owner & ba0_ack;
        game_dst  = ~owner & ba0_dst;
        game_rdy  = ~owner & ba0_rdy;
    end

    // Also relies on the game never asking for both at once
    rd_wr_excl_a: assert property (@(posedge clk) disable iff (prst)
        !(ba0_rd && ba0_wr));

endmodule

// ==== verilog/cheat_hub.sv ====
/*
 Cheat and debug hub between a game core and SDRAM bank 0.
 An external 8-bit controller drives the port bus. Single clock domain.
 ctrl_reset is meant for the controller only.
*/
module cheat_hub #(
    parameter int                AW         = 22,
    parameter cheat_pkg::stamp_t BUILD_TIME = 32'h0,
    parameter cheat_pkg::stamp_t UNLOCK_KEY = 32'h5A3C_96E1
) (
    input  logic              clk,
    input  logic              prst,
    input  logic              lvbl,
    // Port bus
    input  cheat_pkg::byte_t  port_id,
    input  cheat_pkg::byte_t  port_out,
    input  logic              write_strobe,
    input  logic              k_write_strobe,
    input  logic              read_strobe,
    output cheat_pkg::byte_t  port_in,
    output logic              ctrl_reset,
    // Game side
    input  logic [AW-1:0]     game_addr,
    input  logic              game_rd,
    input  logic              game_wr,
    input  cheat_pkg::word_t  game_din,
    input  cheat_pkg::mask_t  game_din_m,
    output logic              game_ack,
    output logic              game_dst,
    output logic              game_rdy,
    // SDRAM bank 0
    output logic [AW-1:0]     ba0_addr,
    output logic              ba0_rd,
    output logic              ba0_wr,
    output cheat_pkg::word_t  ba0_din,
    output cheat_pkg::mask_t  ba0_din_m,
    input  logic              ba0_ack,
    input  logic              ba0_dst,
    input  logic              ba0_rdy,
    input  cheat_pkg::word_t  data_read,
    // Status and debug
    input  cheat_pkg::stamp_t flags,
    input  cheat_pkg::byte_t  joy0,
    input  cheat_pkg::stamp_t timestamp,
    output logic [ 1:0]       led,
    output logic              lock,
    output cheat_pkg::byte_t  st_addr,
    input  cheat_pkg::byte_t  st_dout,
    input  cheat_pkg::byte_t  debug_bus,
    // Video RAM
    output logic [ 9:0]       vram_addr,
    output cheat_pkg::byte_t  vram_dout,
    input  cheat_pkg::byte_t  vram_din,
    output logic              vram_we,
    output logic [ 2:0]       vram_ctrl
);
    logic [AW-1:0]    ctrl_addr;
    cheat_pkg::word_t ctrl_din;
    cheat_pkg::mask_t ctrl_din_m;
    cheat_pkg::word_t ctrl_rdata;
    logic             req_set;
    logic             req_wr;
    logic             kick;
    logic             owner;
    logic             ctrl_busy;
    logic [47:0]      sdram_bytes;
    logic [ 5:0]      frame_cnt;
    logic [23:0]      sec_cnt;

    frame_timer u_timer (
        .clk        (clk),
        .prst       (prst),
        .lvbl       (lvbl),
        .kick       (kick),
        .frame_cnt  (frame_cnt),
        .sec_cnt    (sec_cnt),
        .ctrl_reset (ctrl_reset)
    );

    port_regs #(.AW(AW), .UNLOCK_KEY(UNLOCK_KEY)) u_regs (
        .clk            (clk),
        .prst           (prst),
        .port_id        (port_id),
        .port_out       (port_out),
        .write_strobe   (write_strobe),
        .k_write_strobe (k_write_strobe),
        .ctrl_addr      (ctrl_addr),
        .ctrl_din       (ctrl_din),
        .ctrl_din_m     (ctrl_din_m),
        .req_set        (req_set),
        .req_wr         (req_wr),
        .kick           (kick),
        .sdram_bytes    (sdram_bytes),
        .vram_addr      (vram_addr),
        .vram_dout      (vram_dout),
        .vram_we        (vram_we),
        .vram_ctrl      (vram_ctrl),
        .st_addr        (st_addr),
        .led            (led),
        .locked         (lock)
    );

    port_read_mux #(.BUILD_TIME(BUILD_TIME)) u_rdmux (
        .clk         (clk),
        .prst        (prst),
        .port_id     (port_id),
        .read_strobe (read_strobe),
        .sdram_bytes (sdram_bytes),
        .ctrl_rdata  (ctrl_rdata),
        .vram_din    (vram_din),
        .st_dout     (st_dout),
        .debug_bus   (debug_bus),
        .flags       (flags),
        .joy0        (joy0),
        .timestamp   (timestamp),
        .frame_cnt   (frame_cnt),
        .sec_cnt     (sec_cnt),
        .owner       (owner),
        .ctrl_busy   (ctrl_busy),
        .lvbl        (lvbl),
        .locked      (lock),
        .port_in     (port_in)
    );

    sdram_arbiter #(.AW(AW)) u_arb (
        .clk        (clk),
        .prst       (prst),
        .game_addr  (game_addr),
        .game_rd    (game_rd),
        .game_wr    (game_wr),
        .game_din   (game_din),
        .game_din_m (game_din_m),
        .game_ack   (game_ack),
        .game_dst   (game_dst),
        .game_rdy   (game_rdy),
        .ba0_addr   (ba0_addr),
        .ba0_rd     (ba0_rd),
        .ba0_wr     (ba0_wr),
        .ba0_din    (ba0_din),
        .ba0_din_m  (ba0_din_m),
        .ba0_ack    (ba0_ack),
        .ba0_dst    (ba0_dst),
        .ba0_rdy    (ba0_rdy),
        .data_read  (data_read),
        .ctrl_addr  (ctrl_addr),
        .ctrl_din   (ctrl_din),
        .ctrl_din_m (ctrl_din_m),
        .req_set    (req_set),
        .req_wr     (req_wr),
        .ctrl_rdata (ctrl_rdata),
        .owner      (owner),
        .ctrl_busy  (ctrl_busy)
    );

endmodule

// ==== verification/cheat_hub_tb.sv ====
/*
 Testbench for the cheat hub. The port bus, the game side and lvbl are
 driven 1 ns after the rising edge. Bank 0 is modelled as 256 words
 indexed by the low address byte, with random ack and dst latency.
 Bank write mask: a set bit keeps the old byte.
*/
module cheat_hub_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] BUILD_TIME     = 32'h1234_5678;
    localparam logic [31:0] UNLOCK_KEY     = 32'hC0DE_5A17;
    localparam int          FRAMES_PER_SEC = 60;
    localparam int          WDOG_FRAMES    = 8;
    localparam int          FRAME_CYCLES   = 8;
    // Run length estimate: frames, port bus cycles, SDRAM accesses with polling
    localparam int     FRAMES_RUN = 160;
    localparam int     PORT_OPS   = 120;
    localparam int     SD_OPS     = 6;
    localparam longint TIMEOUT_NS =
        longint'(10 * (FRAMES_RUN * FRAME_CYCLES + PORT_OPS * 2 + SD_OPS * 40)) * 10;

    logic        clk = 1'b0;
    logic        prst, lvbl, ctrl_reset, lock;
    logic [7:0]  port_id, port_out, port_in;
    logic        write_strobe, k_write_strobe, read_strobe;
    logic [21:0] game_addr, ba0_addr;
    logic        game_rd, game_wr, game_ack, game_dst, game_rdy;
    logic [15:0] game_din, ba0_din, data_read;
    logic [1:0]  game_din_m, ba0_din_m, led;
    logic        ba0_rd, ba0_wr, ba0_ack, ba0_dst, ba0_rdy;
    logic [31:0] flags, timestamp;
    logic [7:0]  joy0, st_addr, st_dout, debug_bus, vram_dout, vram_din;
    logic [9:0]  vram_addr;
    logic        vram_we;
    logic [2:0]  vram_ctrl;

    logic [15:0] bank [256];
    logic [21:0] served [$];  // Bank addresses in the order they were acked
    int          err_count = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          frames_done = 0;
    int          since_kick = 0;

    cheat_hub #(.AW(22), .BUILD_TIME(BUILD_TIME), .UNLOCK_KEY(UNLOCK_KEY)) i_dut (.*);

    always #5 clk = ~clk;

    // Reference functions
    function automatic logic [15:0] fill_word(logic [7:0] a);
        return {a ^ 8'hA5, a + 8'h11};
    endfunction

    function automatic logic [15:0] merge_ref(logic [15:0] old, logic [15:0] din, logic [1:0] m);
        return {m[1] ? old[15:8] : din[15:8], m[0] ? old[7:0] : din[7:0]};
    endfunction

    function automatic logic [7:0] status_ref(logic own, logic busy, logic vb, logic lk);
        return {own, busy, vb, 4'b0000, lk};
    endfunction

    function automatic logic [9:0] vram_addr_ref(logic [7:0] lo, logic [7:0] hi);
        return {hi[4:0], lo[4:0]};
    endfunction

    function automatic logic [7:0] frame_ref(int frames);
        return 8'(frames % FRAMES_PER_SEC);
    endfunction

    function automatic logic [7:0] cur_time_ref(logic [31:0] ts, int frames, int idx);
        logic [31:0] t;
        t = ts + 32'(frames / FRAMES_PER_SEC);
        return t[8*idx +: 8];
    endfunction

    function automatic logic wdog_ref(int frames);
        return frames >= WDOG_FRAMES;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("test %-10s %s", name, (test_errs == 0) ? "ok" : "FAILED");
        test_errs = 0;
    endtask

    task automatic port_write(input logic [7:0] id, input logic [7:0] data, input logic konst);
        @(posedge clk);
        #1;
        port_id        = id;
        port_out       = data;
        write_strobe   = ~konst;
        k_write_strobe = konst;
        @(posedge clk);
        #1;
        write_strobe   = 1'b0;
        k_write_strobe = 1'b0;
    endtask

    task automatic port_read(input logic [7:0] id, output logic [7:0] data);
        @(posedge clk);
        #1;
        port_id     = id;
        read_strobe = 1'b1;
        @(posedge clk);
        #1;
        read_strobe = 1'b0;
        data        = port_in;  // Registered on the edge just passed
    endtask

    task automatic expect_port(input string name, input logic [7:0] id, input logic [7:0] exp);
        logic [7:0] data;
        port_read(id, data);
        check(name, 32'(exp), 32'(data));
    endtask

    task automatic run_frame;
        @(posedge clk);
        #1;
        lvbl = 1'b0;
        repeat (FRAME_CYCLES / 2) @(posedge clk);
        #1;
        lvbl = 1'b1;
        repeat (FRAME_CYCLES / 2 - 1) @(posedge clk);
        #1;
        frames_done++;
        since_kick++;
    endtask

    task automatic kick_wdog;
        port_write(8'h40, 8'h00, 1'b0);
        since_kick = 0;
    endtask

    task automatic sd_setup(input logic [23:0] addr, input logic [15:0] data, input logic [1:0] m);
        port_write(8'h00, addr[7:0], 1'b0);
        port_write(8'h01, addr[15:8], 1'b0);
        port_write(8'h02, addr[23:16], 1'b0);
        port_write(8'h03, data[7:0], 1'b0);
        port_write(8'h04, data[15:8], 1'b0);
        port_write(8'h05, {6'd0, m}, 1'b0);
    endtask

    task automatic wait_idle;  // Polls status until busy clears
        logic [7:0] st;
        do port_read(8'h80, st); while (st[6]);
    endtask

    task automatic game_access(input logic wr, input logic [21:0] addr, input logic [15:0] din,
                               input logic [1:0] m, output logic [15:0] dout);
        @(posedge clk);
        #1;
        game_addr  = addr;
        game_din   = din;
        game_din_m = m;
        game_rd    = ~wr;
        game_wr    = wr;
        do @(negedge clk); while (!game_ack);
        @(posedge clk);
        #1;
        game_rd = 1'b0;
        game_wr = 1'b0;
        do @(negedge clk); while (!game_rdy);
        check("game dst", 1, game_dst);
        dout = data_read;  // dst comes with rdy
    endtask

    // Bank 0 model
    initial begin
        ba0_ack   = 1'b0;
        ba0_dst   = 1'b0;
        ba0_rdy   = 1'b0;
        data_read = '0;
        for (int i = 0; i < 256; i++) bank[i] = fill_word(8'(i));
    end

    always begin : bank_model
        logic [21:0] addr;
        logic        wr;
        logic [15:0] din;
        logic [1:0]  msk;
        @(negedge clk);
        if (!prst && (ba0_rd || ba0_wr)) begin
            addr = ba0_addr;
            wr   = ba0_wr;
            din  = ba0_din;
            msk  = ba0_din_m;
            repeat ($urandom_range(4, 1)) @(posedge clk);
            #1;
            ba0_ack = 1'b1;
            served.push_back(addr);
            if (wr) bank[addr[7:0]] = merge_ref(bank[addr[7:0]], din, msk);
            @(posedge clk);
            #1;
            ba0_ack = 1'b0;
            repeat ($urandom_range(4, 1)) @(posedge clk);
            #1;
            ba0_dst   = 1'b1;
            ba0_rdy   = 1'b1;
            data_read = bank[addr[7:0]];
            @(posedge clk);
            #1;
            ba0_dst = 1'b0;
            ba0_rdy = 1'b0;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [7:0]  vals [6];
        logic [15:0] gdata;
        logic [15:0] sd_word;
        logic [31:0] wrong_key;
        void'($urandom(85600));
        prst = 1'b1;
        lvbl = 1'b1;
        port_id = '0;
        port_out = '0;
        write_strobe = 1'b0;
        k_write_strobe = 1'b0;
        read_strobe = 1'b0;
        game_addr = '0;
        game_rd = 1'b0;
        game_wr = 1'b0;
        game_din = '0;
        game_din_m = '0;
        flags = $urandom();
        joy0 = 8'($urandom());
        timestamp = 32'h0000_00FF;  // Carry crosses into byte 1
        st_dout = 8'($urandom());
        debug_bus = 8'($urandom());
        vram_din = 8'($urandom());
        repeat (3) @(posedge clk);
        #1;
        prst = 1'b0;

        check("reset ba0_rd", 0, ba0_rd);
        check("reset ba0_wr", 0, ba0_wr);
        check("reset vram_we", 0, vram_we);
        check("reset led", 0, led);
        check("reset ctrl_reset", 0, ctrl_reset);
        check("reset port_in", 0, port_in);
        check("reset lock", 1, lock);
        end_test("reset");

        for (int i = 0; i < 6; i++) begin
            vals[i] = 8'($urandom());
            port_write(8'(i), vals[i], i[0]);  // Odd ids by constant write
        end
        for (int i = 0; i < 6; i++) expect_port($sformatf("sdram byte %0d", i), 8'(i), vals[i]);
        port_write(8'h06, 8'h03, 1'b0);
        check("led", 2'b11, led);
        port_write(8'h0C, 8'hA7, 1'b1);
        check("st_addr", 8'hA7, st_addr);
        port_write(8'h08, 8'h35, 1'b0);
        port_write(8'h09, 8'h2B, 1'b0);
        check("vram_addr", vram_addr_ref(8'h35, 8'h2B), vram_addr);
        port_write(8'h0B, 8'h0D, 1'b0);
        check("vram_ctrl", 3'h5, vram_ctrl);
        port_write(8'h0A, 8'h41, 1'b0);
        check("vram_we high", 1, vram_we);
        check("vram_dout", 8'hC1, vram_dout);
        @(posedge clk);
        #1;
        check("vram_we low", 0, vram_we);
        expect_port("status data", 8'h0D, st_dout);
        expect_port("debug bus", 8'h0F, debug_bus);
        for (int i = 0; i < 4; i++) expect_port("flags", 8'(8'h10 + i), flags[8*i +: 8]);
        expect_port("joystick", 8'h18, joy0);
        expect_port("vram data", 8'h0A, vram_din);
        expect_port("unmapped", 8'h0E, 8'h00);
        expect_port("status", 8'h80, status_ref(1'b0, 1'b0, lvbl, 1'b1));
        end_test("registers");

        repeat (130) run_frame();
        expect_port("frame count", 8'h2C, frame_ref(frames_done));
        for (int i = 0; i < 4; i++) begin
            expect_port("current time", 8'(8'h28 + i), cur_time_ref(timestamp, frames_done, i));
            expect_port("build time", 8'(8'h24 + i), BUILD_TIME[8*i +: 8]);
            expect_port("timestamp", 8'(8'h20 + i), timestamp[8*i +: 8]);
        end
        check("watchdog after time run", wdog_ref(since_kick), ctrl_reset);
        end_test("time");

        sd_word = fill_word(8'h3E);
        sd_word = {sd_word[15:8], 8'hEF};  // High byte masked off
        sd_setup(24'h2A5C3E, 16'hBEEF, 2'b10);
        port_write(8'hC0, 8'h00, 1'b0);
        wait_idle();
        check("sd write addr", 22'h2A5C3E, served[$]);
        check("sd write data", sd_word, bank[8'h3E]);
        port_write(8'h80, 8'h00, 1'b0);
        wait_idle();
        expect_port("sd read lo", 8'h06, sd_word[7:0]);
        expect_port("sd read hi", 8'h07, sd_word[15:8]);
        end_test("sdram");

        game_access(1'b1, 22'h000033, 16'h1357, 2'b00, gdata);
        check("game write", 16'h1357, bank[8'h33]);
        game_access(1'b0, 22'h000033, 16'h0000, 2'b00, gdata);
        check("game read", 16'h1357, gdata);
        served.delete();
        sd_setup(24'h2A5C3E, 16'h0000, 2'b00);
        fork
            port_write(8'h80, 8'h00, 1'b0);
            begin
                // Game asks one cycle later so both are pending at the same decision
                @(posedge clk);
                game_access(1'b0, 22'h000010, 16'h0000, 2'b00, gdata);
            end
        join
        wait_idle();
        check("both served", 2, served.size());
        check("game first", 22'h000010, served[0]);
        check("controller second", 22'h2A5C3E, served[1]);
        check("game data", fill_word(8'h10), gdata);
        expect_port("ctrl data lo", 8'h06, sd_word[7:0]);
        expect_port("ctrl data hi", 8'h07, sd_word[15:8]);
        end_test("game");

        wrong_key = UNLOCK_KEY ^ 32'h0000_0100;
        for (int i = 0; i < 4; i++) port_write(8'(8'h30 + i), wrong_key[8*i +: 8], 1'b0);
        check("wrong key", 1, lock);
        for (int i = 0; i < 4; i++) port_write(8'(8'h30 + i), UNLOCK_KEY[8*i +: 8], 1'b0);
        check("right key", 0, lock);
        expect_port("status unlocked", 8'h80, status_ref(1'b0, 1'b0, lvbl, 1'b0));
        end_test("lock");

        kick_wdog();
        check("kick clears", wdog_ref(since_kick), ctrl_reset);
        repeat (7) run_frame();
        check("7 frames", wdog_ref(since_kick), ctrl_reset);
        run_frame();
        check("8 frames", wdog_ref(since_kick), ctrl_reset);
        port_write(8'h40, 8'h00, 1'b1);  // Constant write is no kick
        check("constant write", wdog_ref(since_kick), ctrl_reset);
        kick_wdog();
        check("kick after trip", wdog_ref(since_kick), ctrl_reset);
        repeat (7) run_frame();
        kick_wdog();
        repeat (7) run_frame();
        check("kept low", wdog_ref(since_kick), ctrl_reset);
        end_test("watchdog");

        $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
verilog/cheat_pkg.sv
verilog/frame_timer.sv
verilog/port_regs.sv
verilog/port_read_mux.sv
verilog/sdram_arbiter.sv
verilog/cheat_hub.sv
verification/cheat_hub_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the cheat hub testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module cheat_hub_tb -o sim_cheat_hub

output=$(./obj_dir/sim_cheat_hub)
echo "$output"

if grep -q "sim passed" <<< "$output"; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
